/* sim/zports_patterns.txt */
# op addr data exp, all hex; w write, r read (data = expected hit), k keys: data = {tape, keys}
# c config: addr 0 sysconf 1 memconf 2 im2vect 3 fmaddr 4 rampage 3..0; i IDE word; v video; z reset
c 0 0 01
c 1 0 04
c 2 0 ff
c 4 0 00020500
r 10af 1 00
r 11af 1 05
r 12af 1 02
r 13af 1 00
w 20af 5a 0
w 21af 08 0
w 25af c3 0
w 15af 1d 0
w 10af 11 0
w 11af 22 0
w 12af 33 0
w 13af 44 0
w 07af 9e 0
v 07 0 9e
c 0 0 5a
c 1 0 08
c 2 0 c3
c 3 0 1d
c 4 0 44332211
w 11af 66 0
r 11af 1 66
r 20af 1 ff
w 7ffd d3 0
c 1 0 09
c 4 0 1b336611
w 21af 40 0
w 7ffd c5 0
c 4 0 05336611
w 7ffd 22 0
w 7ffd 17 0
c 1 0 40
c 4 0 02336611
z 0 0 0
w 7ffd 07 0
c 4 0 07020500
w 0011 ab 0
w 0010 cd 0
r 0010 1 cd
r 0011 1 ab
r 0030 1 31
i 0 0 abcd
k 0 2a 0
r 00fe 1 ca
w 00fe 05 0
v 00 1 05
r 0077 0 ff
r 80fd 0 ff

/* zports.f */
src/zports_pkg.sv
src/port_decode.sv
src/xt_config_regs.sv
src/ide_bridge.sv
src/port_readback.sv
src/zports_top.sv
sim/zports_props.sv
sim/zports_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= zports_tb
FILELIST  ?= zports.f
BUILD_DIR ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* sim/zports_tb.sv */
// plays sim/zports_patterns.txt from the project root; IDE model word = {cs1 active, addr}
module zports_tb;

	logic                 zclk;
	logic                 rst;
	logic                 io_stb;
	zports_pkg::io_req_t  io_req;
	logic [4:0]           keys;
	logic                 tape_in;
	logic [15:0]          ide_rdata;
	logic                 rd_valid;
	zports_pkg::rd_resp_t rd_resp;
	zports_pkg::sys_cfg_t cfg;
	logic                 vid_stb;
	zports_pkg::vid_wr_t  vid_wr;
	zports_pkg::ide_bus_t ide_bus;

	logic [15:0]         ide_mem [16];
	logic [3:0]          ide_idx;
	logic [7:0]          stb_lo;	// low address byte of the access in its strobe cycle
	logic [8:0]          exp_q [$];	// {hit, data} per outstanding read
	int                  vid_count = 0;
	int                  vid_checked = 0;
	zports_pkg::vid_wr_t vid_last;
	int                  checks = 0;
	int                  mismatches = 0;
	int                  timeouts = 0;
	int                  failures = 0;
	int                  rsp_checks = 0;
	int                  rsp_mismatches = 0;
	int                  rsp_extra = 0;
	int                  bus_errors = 0;

	zports_top zports_top_i (.*);

	initial
	begin
		zclk = 1'b0;
		forever
			#10 zclk = ~zclk;
	end

	// IDE device model
	assign ide_idx   = {!ide_bus.cs1_n, ide_bus.addr};
	assign ide_rdata = ide_bus.rd_n ? 16'h0000 : ide_mem[ide_idx];

	initial
	begin
		for (int i = 0; i < 16; i++)
			ide_mem[i] = {4'hC, i[3:0], 4'h3, i[3:0]};	// every word distinct
	end

	// one edge behind io_stb, lines up with the IDE strobe
	always @(posedge zclk)
	begin
		stb_lo <= io_stb ? io_req.addr[7:0] : 8'h00;
	end

	always @(posedge zclk)
	begin
		if (!ide_bus.wr_n)
			ide_mem[ide_idx] <= ide_bus.wdata;
		if (!ide_bus.rd_n || !ide_bus.wr_n)
		begin
			if (ide_bus.cs0_n == ide_bus.cs1_n)
			begin
				$display("mismatch at %0t: IDE strobe with cs0_n %b and cs1_n %b",
					$time, ide_bus.cs0_n, ide_bus.cs1_n);
				bus_errors++;
			end
			if (stb_lo == zports_pkg::IDE_HI)	// high byte port stays off the bus
			begin
				$display("IDE bus cycle at %0t for a port #11 access", $time);
				bus_errors++;
			end
		end
	end

	always @(posedge zclk)
	begin : response_check
		logic [8:0] want;
		if (vid_stb)
		begin
			vid_count <= vid_count + 1;
			vid_last  <= vid_wr;
		end
		if (rd_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("read response at %0t with no read outstanding", $time);
				rsp_extra++;
			end
			else
			begin
				want = exp_q.pop_front();
				rsp_checks++;
				if ({rd_resp.hit, rd_resp.data} !== want)
				begin
					$display("mismatch at %0t: read data %h hit %b, expected data %h hit %b",
						$time, rd_resp.data, rd_resp.hit, want[7:0], want[8]);
					rsp_mismatches++;
				end
			end
		end
	end

	task automatic apply_reset();
		@(posedge zclk);
		#2;
		rst = 1'b1;
		repeat (10) @(posedge zclk);
		#2;
		rst = 1'b0;
	endtask

	task automatic drive(input logic rd, input logic [15:0] addr, input logic [7:0] data);
		@(posedge zclk);
		#2;
		io_stb      = 1'b1;
		io_req.addr = addr;
		io_req.data = data;
		io_req.rd   = rd;
		io_req.wr   = !rd;
	endtask

	// stop strobing, let writes land and outstanding reads return
	task automatic drain();
		int t;
		@(posedge zclk);
		#2;
		io_stb    = 1'b0;
		io_req.rd = 1'b0;
		io_req.wr = 1'b0;
		repeat (3) @(posedge zclk);
		#2;
		t = 0;
		while (exp_q.size() != 0 && t < 16)
		begin
			@(posedge zclk);
			#2;
			t++;
		end
		if (exp_q.size() != 0)
		begin
			$display("timeout at %0t: %0d read responses never came", $time, exp_q.size());
			timeouts++;
			exp_q.delete();
		end
	endtask

	task automatic run_line(input string line);
		byte         op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] got;
		op = line.getc(0);
		if ($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e) != 3)
		begin
			$display("pattern line could not be parsed: %s", line);
			failures++;
			return;
		end
		case (op)
			"w":
				drive(1'b0, a[15:0], d[7:0]);
			"r":
			begin
				exp_q.push_back({d[0], e[7:0]});
				drive(1'b1, a[15:0], 8'h00);
			end
			"c":
			begin
				drain();
				case (a[2:0])
					3'd0: got = {24'h0, cfg.sysconf};
					3'd1: got = {24'h0, cfg.memconf};
					3'd2: got = {24'h0, cfg.im2vect};
					3'd3: got = {27'h0, cfg.fmaddr};
					default: got = cfg.rampage;	// page 3 in the top byte
				endcase
				checks++;
				if (got !== e)
				begin
					$display("mismatch at %0t: config field %0d is %h, expected %h",
						$time, a, got, e);
					mismatches++;
				end
			end
			"i":
			begin
				drain();
				checks++;
				if (ide_mem[a[3:0]] !== e[15:0])
				begin
					$display("mismatch at %0t: IDE word %0d is %h, expected %h",
						$time, a, ide_mem[a[3:0]], e[15:0]);
					mismatches++;
				end
			end
			"v":
			begin
				drain();
				checks++;
				if (vid_count != vid_checked + 1)
				begin
					$display("expected one video write before the check at %0t, saw %0d",
						$time, vid_count - vid_checked);
					failures++;
				end
				else if (vid_last.index !== a[7:0] || vid_last.border !== d[0]
					|| vid_last.data !== e[7:0])
				begin
					$display("mismatch at %0t: video write %h/%b/%h, expected %h/%b/%h", $time,
						vid_last.index, vid_last.border, vid_last.data, a[7:0], d[0], e[7:0]);
					mismatches++;
				end
				vid_checked = vid_count;
			end
			"k":
			begin
				drain();
				keys    = d[4:0];
				tape_in = d[5];
			end
			"z":
			begin
				drain();
				apply_reset();
			end
			default:
			begin
				$display("unknown op in pattern line: %s", line);
				failures++;
			end
		endcase
	endtask

	initial
	begin : playback
		string line;
		int    fd;
		int    n;
		rst     = 1'b1;
		io_stb  = 1'b0;
		io_req  = '0;
		keys    = 5'h00;
		tape_in = 1'b0;
		apply_reset();
		fd = $fopen("sim/zports_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the pattern file sim/zports_patterns.txt");
			failures++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#")
					run_line(line);
			end
			$fclose(fd);
			drain();
		end
		$display("checks %0d, mismatches %0d, timeouts %0d, other failures %0d",
			checks + rsp_checks, mismatches + rsp_mismatches, timeouts,
			failures + rsp_extra + bus_errors);
		if (mismatches + rsp_mismatches + timeouts + failures + rsp_extra + bus_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* sim/zports_props.sv */
// bound into zports_top; assumes reads are only strobed with rst low
module zports_props (
	input logic                 zclk,
	input logic                 rst,
	input logic                 io_stb,
	input zports_pkg::io_req_t  io_req,
	input logic                 rd_valid,
	input logic                 vid_stb,
	input zports_pkg::ide_bus_t ide_bus
);

	// two register stages between strobe and response
	assert property (@(posedge zclk) disable iff (rst) io_stb && io_req.rd |-> ##2 rd_valid)
		else $error("rd_valid did not follow a read strobe after two cycles");

	assert property (@(posedge zclk) !(!ide_bus.rd_n && !ide_bus.wr_n))
		else $error("IDE rd_n and wr_n low in the same cycle");

	// one edge of reset clears every strobe
	assert property (@(posedge zclk) rst |=> (!rd_valid && !vid_stb && ide_bus.rd_n
		&& ide_bus.wr_n && ide_bus.cs0_n && ide_bus.cs1_n))
		else $error("strobe active while in reset");

endmodule

bind zports_top zports_props zports_props_i (.*);

/* src/zports_top.sv */
// single clock zclk, sync active-high rst; one io_stb per cycle at most, never stalled
module zports_top #(
	parameter logic [7:0] XT_PORT = zports_pkg::PORT_XT_DEFAULT
) (
	input  logic                 zclk,
	input  logic                 rst,
	input  logic                 io_stb,
	input  zports_pkg::io_req_t  io_req,
	input  logic [4:0]           keys,
	input  logic                 tape_in,
	input  logic [15:0]          ide_rdata,
	output logic                 rd_valid,
	output zports_pkg::rd_resp_t rd_resp,
	output zports_pkg::sys_cfg_t cfg,
	output logic                 vid_stb,
	output zports_pkg::vid_wr_t  vid_wr,
	output zports_pkg::ide_bus_t ide_bus
);

	logic                  sel_stb;
	zports_pkg::port_sel_t sel;
	logic [7:0]            ide_rbyte;

	port_decode #(
		.XT_PORT (XT_PORT)
	) port_decode_i (
		.zclk    (zclk),
		.rst     (rst),
		.io_stb  (io_stb),
		.io_req  (io_req),
		.sel_stb (sel_stb),
		.sel     (sel)
	);

	xt_config_regs xt_config_regs_i (
		.zclk    (zclk),
		.rst     (rst),
		.sel_stb (sel_stb),
		.sel     (sel),
		.cfg     (cfg),
		.vid_stb (vid_stb),
		.vid_wr  (vid_wr)
	);

	ide_bridge ide_bridge_i (
		.zclk      (zclk),
		.rst       (rst),
		.sel_stb   (sel_stb),
		.sel       (sel),
		.ide_rdata (ide_rdata),
		.ide_bus   (ide_bus),
		.ide_rbyte (ide_rbyte)
	);

	// read mux sees cfg already updated by a write one access earlier
	port_readback port_readback_i (
		.zclk      (zclk),
		.rst       (rst),
		.sel_stb   (sel_stb),
		.sel       (sel),
		.cfg       (cfg),
		.keys      (keys),
		.tape_in   (tape_in),
		.ide_rbyte (ide_rbyte),
		.rd_valid  (rd_valid),
		.rd_resp   (rd_resp)
	);

endmodule

/* src/port_readback.sv */
// one registered response per read; unimplemented ports read #FF with hit clear
module port_readback (
	input  logic                  zclk,
	input  logic                  rst,
	input  logic                  sel_stb,
	input  zports_pkg::port_sel_t sel,
	input  zports_pkg::sys_cfg_t  cfg,
	input  logic [4:0]            keys,
	input  logic                  tape_in,
	input  logic [7:0]            ide_rbyte,
	output logic                  rd_valid,
	output zports_pkg::rd_resp_t  rd_resp
);

	logic [7:0] idx;
	logic [7:0] rdata;
	logic       rd_acc;

	assign idx    = sel.req.addr[15:8];
	assign rd_acc = sel_stb && sel.req.rd;

	always_comb
	begin
		case (sel.pclass)
			zports_pkg::PC_FE:
				rdata = {1'b1, tape_in, 1'b0, keys};
			zports_pkg::PC_IDE_LO, zports_pkg::PC_IDE_HI,
			zports_pkg::PC_IDE_REG, zports_pkg::PC_IDE_CTL:
				rdata = ide_rbyte;
			zports_pkg::PC_XT:
				if (idx[7:2] == zports_pkg::XT_RAMPAGE_BASE[7:2])
					rdata = cfg.rampage[idx[1:0]];
				else
					rdata = 8'hFF;	// other indices are write only
			default:
				rdata = 8'hFF;
		endcase
	end

	always_ff @(posedge zclk)
	begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_acc;
	end

	always_ff @(posedge zclk)
	begin
		if (rd_acc)
		begin
			rd_resp.data <= rdata;
			rd_resp.hit  <= sel.hit;
		end
	end

endmodule

/* src/ide_bridge.sv */
// normal byte order only: write #11 then #10, read #10 then #11; strobes follow sel_stb combinationally
module ide_bridge (
	input  logic                  zclk,
	input  logic                  rst,
	input  logic                  sel_stb,
	input  zports_pkg::port_sel_t sel,
	input  logic [15:0]           ide_rdata,
	output zports_pkg::ide_bus_t  ide_bus,
	output logic [7:0]            ide_rbyte
);

	logic       is_lo;
	logic       is_hi;
	logic       is_ctl;
	logic       ide_cyc;	// a real IDE bus cycle this clock
	logic [7:0] wr_hi;	// high byte waiting for the #10 write
	logic [7:0] rd_hi;	// high byte left over from the #10 read

	assign is_lo  = (sel.pclass == zports_pkg::PC_IDE_LO);
	assign is_hi  = (sel.pclass == zports_pkg::PC_IDE_HI);
	assign is_ctl = (sel.pclass == zports_pkg::PC_IDE_CTL);

	// #11 never reaches the device
	assign ide_cyc = sel_stb
		&& (is_lo || is_ctl || (sel.pclass == zports_pkg::PC_IDE_REG));

	always_comb
	begin
		ide_bus.addr  = sel.req.addr[7:5];
		ide_bus.cs0_n = !(ide_cyc && !is_ctl);
		ide_bus.cs1_n = !(ide_cyc && is_ctl);
		ide_bus.rd_n  = !(ide_cyc && sel.req.rd);
		ide_bus.wr_n  = !(ide_cyc && sel.req.wr);
		if (is_lo)
			ide_bus.wdata = {wr_hi, sel.req.data};
		else
			ide_bus.wdata = {sel.req.data, sel.req.data};	// 8-bit registers on both halves
	end

	// byte returned to the Z80 for the read in this cycle
	assign ide_rbyte = is_hi ? rd_hi : ide_rdata[7:0];

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			wr_hi <= 8'h00;
			rd_hi <= 8'h00;
		end
		else if (sel_stb)
		begin
			if (is_hi && sel.req.wr)
				wr_hi <= sel.req.data;
			if (is_lo && sel.req.rd)
				rd_hi <= ide_rdata[15:8];	// sampled as rd_n goes back high
		end
	end

endmodule

/* src/xt_config_regs.sv */
// writes land one edge after sel_stb; 128K lock is memconf bit 6 only, #7FFD frozen by lock48
module xt_config_regs (
	input  logic                  zclk,
	input  logic                  rst,
	input  logic                  sel_stb,
	input  zports_pkg::port_sel_t sel,
	output zports_pkg::sys_cfg_t  cfg,
	output logic                  vid_stb,
	output zports_pkg::vid_wr_t   vid_wr
);

	logic [7:0] idx;	// extended register index
	logic [7:0] din;
	logic       wr_acc;
	logic       xt_wr;
	logic       fe_wr;
	logic       p7ffd_wr;
	logic       lock48;
	logic       lock128;
	logic [1:0] pg_hi;	// rampage 3 bits 4..3 from #7FFD

	assign idx     = sel.req.addr[15:8];
	assign din     = sel.req.data;
	assign wr_acc  = sel_stb && sel.req.wr;
	assign xt_wr   = wr_acc && (sel.pclass == zports_pkg::PC_XT);
	assign fe_wr   = wr_acc && (sel.pclass == zports_pkg::PC_FE);
	assign p7ffd_wr = wr_acc && (sel.pclass == zports_pkg::PC_FD7FFD) && !lock48;

	assign lock128 = cfg.memconf[6];
	assign pg_hi   = lock128 ? 2'b00 : din[7:6];

	// video and border writes go out in the strobe cycle itself
	always_comb
	begin
		vid_stb       = 1'b0;
		vid_wr.index  = idx;
		vid_wr.data   = din;
		vid_wr.border = 1'b0;
		if (fe_wr)
		begin
			vid_stb       = 1'b1;
			vid_wr.index  = 8'h00;	// border carries no index
			vid_wr.border = 1'b1;
		end
		else if (xt_wr && zports_pkg::is_vid_index(idx))
			vid_stb = 1'b1;
	end

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			cfg.sysconf   <= zports_pkg::SYSCONF_RST;
			cfg.memconf   <= zports_pkg::MEMCONF_RST;
			cfg.im2vect   <= zports_pkg::IM2VECT_RST;
			cfg.fmaddr[4] <= 1'b0;	// FM window off, address bits kept
			cfg.rampage   <= zports_pkg::RAMPAGE_RST;
		end
		else if (p7ffd_wr)
		begin
			cfg.memconf[0] <= din[4];	// ROM select
			cfg.rampage[3] <= {3'b000, pg_hi, din[2:0]};
		end
		else if (xt_wr)
		begin
			if (idx[7:2] == zports_pkg::XT_RAMPAGE_BASE[7:2])
				cfg.rampage[idx[1:0]] <= din;
			if (idx == zports_pkg::XT_FMADDR)
				cfg.fmaddr <= din[4:0];
			if (idx == zports_pkg::XT_SYSCONF)
				cfg.sysconf <= din;
			if (idx == zports_pkg::XT_MEMCONF)
				cfg.memconf <= din;
			if (idx == zports_pkg::XT_IM2VECT)
				cfg.im2vect <= din;
		end
	end

	// 48K lock, only a reset releases it
	always_ff @(posedge zclk)
	begin
		if (rst)
			lock48 <= 1'b0;
		else if (p7ffd_wr)
			lock48 <= din[5];
	end

endmodule

/* src/port_decode.sv */
// one cycle of latency; XT_PORT must not collide with another implemented low byte
module port_decode #(
	parameter logic [7:0] XT_PORT = zports_pkg::PORT_XT_DEFAULT
) (
	input  logic                  zclk,
	input  logic                  rst,
	input  logic                  io_stb,
	input  zports_pkg::io_req_t   io_req,
	output logic                  sel_stb,
	output zports_pkg::port_sel_t sel
);

	logic [7:0]              lo;
	zports_pkg::port_class_t cls;

	assign lo = io_req.addr[7:0];

	// classify on the raw request, registered below together with it
	always_comb
	begin
		cls = zports_pkg::PC_NONE;
		if (lo == XT_PORT)
			cls = zports_pkg::PC_XT;
		else
		begin
			case (lo)
				zports_pkg::PORT_FE:
					cls = zports_pkg::PC_FE;
				zports_pkg::PORT_FD:
					if (!io_req.addr[15])	// a15 set would be the AY port
						cls = zports_pkg::PC_FD7FFD;
				zports_pkg::IDE_LO:
					cls = zports_pkg::PC_IDE_LO;
				zports_pkg::IDE_HI:
					cls = zports_pkg::PC_IDE_HI;
				zports_pkg::IDE_30, zports_pkg::IDE_50, zports_pkg::IDE_70,
				zports_pkg::IDE_90, zports_pkg::IDE_B0, zports_pkg::IDE_D0,
				zports_pkg::IDE_F0:
					cls = zports_pkg::PC_IDE_REG;
				zports_pkg::IDE_C8:
					cls = zports_pkg::PC_IDE_CTL;
				default:
					cls = zports_pkg::PC_NONE;
			endcase
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst)
			sel_stb <= 1'b0;
		else
			sel_stb <= io_stb;
	end

	// payload only moves on a strobe
	always_ff @(posedge zclk)
	begin
		if (io_stb)
		begin
			sel.req    <= io_req;
			sel.pclass <= cls;
			sel.hit    <= (cls != zports_pkg::PC_NONE);
		end
	end

endmodule

/* src/zports_pkg.sv */
// shared port map, register indices and bus structs; all widths assume a byte-wide Z80 port bus
package zports_pkg;

	// port low bytes
	localparam logic [7:0] PORT_FE         = 8'hFE;
	localparam logic [7:0] PORT_FD         = 8'hFD;	// #7FFD when a15 is clear
	localparam logic [7:0] PORT_XT_DEFAULT = 8'hAF;
	localparam logic [7:0] IDE_LO          = 8'h10;	// data, low byte
	localparam logic [7:0] IDE_HI          = 8'h11;	// data, high byte held in bridge
	localparam logic [7:0] IDE_30          = 8'h30;
	localparam logic [7:0] IDE_50          = 8'h50;
	localparam logic [7:0] IDE_70          = 8'h70;
	localparam logic [7:0] IDE_90          = 8'h90;
	localparam logic [7:0] IDE_B0          = 8'hB0;
	localparam logic [7:0] IDE_D0          = 8'hD0;
	localparam logic [7:0] IDE_F0          = 8'hF0;
	localparam logic [7:0] IDE_C8          = 8'hC8;	// control block, cs1

	// extended port register indices (address high byte)
	localparam logic [7:0] XT_RAMPAGE_BASE = 8'h10;	// #10..#13
	localparam logic [7:0] XT_FMADDR       = 8'h15;
	localparam logic [7:0] XT_SYSCONF      = 8'h20;
	localparam logic [7:0] XT_MEMCONF      = 8'h21;
	localparam logic [7:0] XT_IM2VECT      = 8'h25;

	// video register groups
	localparam logic [7:0] VID_G0_BASE     = 8'h00;	// #00..#0F
	localparam logic [7:0] VID_G1_BASE     = 8'h40;	// #40..#47
	localparam logic [7:0] VID_G2_FIRST    = 8'h22;
	localparam logic [7:0] VID_G2_LAST     = 8'h24;

	// reset values
	localparam logic [7:0]       SYSCONF_RST = 8'h01;
	localparam logic [7:0]       MEMCONF_RST = 8'h04;
	localparam logic [7:0]       IM2VECT_RST = 8'hFF;
	localparam logic [3:0][7:0]  RAMPAGE_RST = {8'h00, 8'h02, 8'h05, 8'h00};	// pages 3..0

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rd;
		logic        wr;
	} io_req_t;

	typedef enum logic [2:0] {
		PC_NONE,
		PC_FE,
		PC_FD7FFD,
		PC_XT,
		PC_IDE_LO,
		PC_IDE_HI,
		PC_IDE_REG,
		PC_IDE_CTL
	} port_class_t;

	typedef struct packed {
		io_req_t     req;
		port_class_t pclass;
		logic        hit;
	} port_sel_t;

	typedef struct packed {
		logic [7:0]      sysconf;
		logic [7:0]      memconf;
		logic [7:0]      im2vect;
		logic [4:0]      fmaddr;
		logic [3:0][7:0] rampage;
	} sys_cfg_t;

	typedef struct packed {
		logic [7:0] index;
		logic [7:0] data;
		logic       border;
	} vid_wr_t;

	typedef struct packed {
		logic [2:0]  addr;
		logic        cs0_n;
		logic        cs1_n;
		logic        rd_n;
		logic        wr_n;
		logic [15:0] wdata;
	} ide_bus_t;

	typedef struct packed {
		logic [7:0] data;
		logic       hit;
	} rd_resp_t;

	// index belongs to one of the video register groups
	function automatic logic is_vid_index(input logic [7:0] idx);
		return (idx[7:4] == VID_G0_BASE[7:4])
			|| (idx[7:3] == VID_G1_BASE[7:3])
			|| ((idx >= VID_G2_FIRST) && (idx <= VID_G2_LAST));
	endfunction

endpackage
